/* list.f */
+incdir+dv
rtl/issue_pkg.sv
rtl/register_file.sv
rtl/scoreboard.sv
rtl/operand_bypass.sv
rtl/issue_select.sv
rtl/issue_stage.sv
dv/tb_issue_stage.sv

/* run.sh */
#!/bin/sh
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_issue_stage \
	-Mdir obj_dir -o tb_issue_stage
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_issue_stage > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the log decides the result
if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

/* dv/issue_tests.svh */
task automatic clear_inputs();
	for (int s = 0; s < 2; s++) begin
		instr[s]       = '0;
		queue_valid[s] = 1'b0;
		commit[s]      = '0;
	end
	for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
		fu_result[k] = '0;
	end
	for (int r = 0; r < 4; r++) begin
		data_out_rob[r] = '0;
	end
	busy_lsu    = 1'b0;
	flush_valid = 1'b0;
	// every ticket kept unless a test says otherwise
	flush_keep  = '1;
endtask

// leaves the bench on a falling edge with idle inputs
task automatic reset_dut();
	rst_n = 1'b0;
	clear_inputs();
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
endtask

task automatic next_step();
	@(negedge clk);
	clear_inputs();
endtask

// combinational outputs are stable well before the rising edge
task automatic settle();
	#(CLK_PERIOD / 4);
endtask

function automatic issue_pkg::renamed_instr_t make_instr(input issue_pkg::preg_t src1,
	input issue_pkg::preg_t src2, input issue_pkg::preg_t dst,
	input issue_pkg::fu_kind_e fu, input issue_pkg::ticket_t ticket);
	issue_pkg::renamed_instr_t r;
	r           = '0;
	r.valid     = 1'b1;
	r.pc        = $urandom();
	r.immediate = $urandom();
	r.src1      = src1;
	r.src2      = src2;
	r.dst       = dst;
	r.fu        = fu;
	r.microop   = 5'd1;
	r.ticket    = ticket;
	return r;
endfunction

task automatic present(input int slot, input issue_pkg::renamed_instr_t ins);
	instr[slot]       = ins;
	queue_valid[slot] = 1'b1;
endtask

// issued fields that come straight from the queue entry
task automatic compare_issued(input int slot, input issue_pkg::renamed_instr_t ins);
	check_value($sformatf("slot%0d valid", slot + 1), 32'd1, 32'(issued[slot].valid));
	check_value($sformatf("slot%0d pc", slot + 1), ins.pc, issued[slot].pc);
	check_value($sformatf("slot%0d dst", slot + 1), 32'(ins.dst), 32'(issued[slot].dst));
	check_value($sformatf("slot%0d fu", slot + 1), 32'(ins.fu), 32'(issued[slot].fu));
	check_value($sformatf("slot%0d microop", slot + 1), 32'(ins.microop),
		32'(issued[slot].microop));
	check_value($sformatf("slot%0d ticket", slot + 1), 32'(ins.ticket),
		32'(issued[slot].ticket));
endtask

task automatic commit_write(input int port, input issue_pkg::preg_t pdst,
	input issue_pkg::ticket_t ticket, input issue_pkg::word_t data);
	commit[port].valid_commit = 1'b1;
	commit[port].valid_write  = 1'b1;
	commit[port].flushed      = 1'b0;
	commit[port].pdst         = pdst;
	commit[port].ticket       = ticket;
	commit[port].data         = data;
endtask

task automatic fu_write(input issue_pkg::fu_kind_e fu, input issue_pkg::preg_t dst,
	input issue_pkg::ticket_t ticket, input issue_pkg::word_t data);
	fu_result[fu].valid  = 1'b1;
	fu_result[fu].dst    = dst;
	fu_result[fu].ticket = ticket;
	fu_result[fu].data   = data;
endtask

task automatic commit_and_read();
	issue_pkg::word_t d1;
	issue_pkg::word_t d2;
	test_name = "commit_and_read";
	d1 = $urandom();
	d2 = $urandom();
	reset_dut();
	commit_write(0, 6'd10, 3'd0, d1);
	commit_write(1, 6'd11, 3'd0, d2);
	next_step();
	present(0, make_instr(6'd10, 6'd11, 6'd12, issue_pkg::FU_ALU1, 3'd1));
	present(1, make_instr(6'd11, 6'd10, 6'd13, issue_pkg::FU_ALU2, 3'd2));
	settle();
	check_value("slot1 issue", 32'd1, 32'(issue[0]));
	check_value("slot2 issue", 32'd1, 32'(issue[1]));
	check_value("slot1 data1", d1, issued[0].data1);
	check_value("slot1 data2", d2, issued[0].data2);
	check_value("slot2 data1", d2, issued[1].data1);
	check_value("slot2 data2", d1, issued[1].data2);
endtask

task automatic stall_and_bypass();
	issue_pkg::word_t res;
	test_name = "stall_and_bypass";
	res = $urandom();
	reset_dut();
	present(0, make_instr(6'd0, 6'd0, 6'd5, issue_pkg::FU_ALU1, 3'd3));
	settle();
	check_value("writer issue", 32'd1, 32'(issue[0]));
	next_step();
	present(0, make_instr(6'd5, 6'd0, 6'd6, issue_pkg::FU_ALU2, 3'd4));
	settle();
	check_value("reader stalls", 32'd0, 32'(issue[0]));
	next_step();
	present(0, make_instr(6'd5, 6'd0, 6'd6, issue_pkg::FU_ALU2, 3'd4));
	fu_write(issue_pkg::FU_ALU1, 6'd5, 3'd3, res);
	settle();
	check_value("reader issue", 32'd1, 32'(issue[0]));
	check_value("bypass data", res, issued[0].data1);
endtask

task automatic rob_forward_and_commit();
	issue_pkg::word_t rob_val;
	issue_pkg::word_t cmt_val;
	test_name = "rob_forward_and_commit";
	rob_val = $urandom();
	cmt_val = $urandom();
	reset_dut();
	present(0, make_instr(6'd0, 6'd0, 6'd5, issue_pkg::FU_ALU1, 3'd3));
	settle();
	check_value("writer issue", 32'd1, 32'(issue[0]));
	next_step();
	fu_write(issue_pkg::FU_ALU1, 6'd5, 3'd3, $urandom());
	next_step();
	present(0, make_instr(6'd5, 6'd0, 6'd7, issue_pkg::FU_ALU2, 3'd4));
	data_out_rob[0] = rob_val;
	settle();
	check_value("rob address", 32'd3, 32'(read_addr_rob[0]));
	check_value("rob reader issue", 32'd1, 32'(issue[0]));
	check_value("rob data", rob_val, issued[0].data1);
	next_step();
	commit_write(0, 6'd5, 3'd3, cmt_val);
	next_step();
	// stale rob data stays on the bus after the commit
	present(0, make_instr(6'd5, 6'd0, 6'd8, issue_pkg::FU_ALU2, 3'd5));
	data_out_rob[0] = rob_val;
	settle();
	check_value("rf reader issue", 32'd1, 32'(issue[0]));
	check_value("rf data", cmt_val, issued[0].data1);
endtask

task automatic pair_rules();
	test_name = "pair_rules";
	reset_dut();
	present(0, make_instr(6'd0, 6'd0, 6'd20, issue_pkg::FU_ALU1, 3'd0));
	present(1, make_instr(6'd20, 6'd0, 6'd21, issue_pkg::FU_ALU2, 3'd1));
	settle();
	check_value("raw slot1", 32'd1, 32'(issue[0]));
	check_value("raw slot2", 32'd0, 32'(issue[1]));
	next_step();
	present(0, make_instr(6'd0, 6'd0, 6'd22, issue_pkg::FU_LSU, 3'd1));
	present(1, make_instr(6'd0, 6'd0, 6'd23, issue_pkg::FU_LSU, 3'd2));
	settle();
	check_value("two lsu slot1", 32'd1, 32'(issue[0]));
	check_value("two lsu slot2", 32'd0, 32'(issue[1]));
	next_step();
	present(0, make_instr(6'd0, 6'd0, 6'd24, issue_pkg::FU_LSU, 3'd2));
	present(1, make_instr(6'd0, 6'd0, 6'd25, issue_pkg::FU_ALU1, 3'd3));
	busy_lsu = 1'b1;
	settle();
	check_value("busy lsu slot1", 32'd0, 32'(issue[0]));
	check_value("busy lsu slot2", 32'd0, 32'(issue[1]));
	next_step();
	present(0, make_instr(6'd0, 6'd0, 6'd0, issue_pkg::FU_ALU1, 3'd4));
	present(1, make_instr(6'd0, 6'd0, 6'd26, issue_pkg::FU_ALU2, 3'd5));
	settle();
	check_value("zero dst slot1", 32'd1, 32'(issue[0]));
	check_value("zero dst slot2", 32'd1, 32'(issue[1]));
	next_step();
	present(0, make_instr(6'd0, 6'd0, 6'd0, issue_pkg::FU_ALU2, 3'd6));
	settle();
	check_value("zero dst again", 32'd1, 32'(issue[0]));
endtask

task automatic flush_pending();
	issue_pkg::word_t v;
	test_name = "flush_pending";
	v = $urandom();
	reset_dut();
	commit_write(0, 6'd9, 3'd0, v);
	next_step();
	present(0, make_instr(6'd0, 6'd0, 6'd9, issue_pkg::FU_ALU1, 3'd6));
	settle();
	check_value("writer issue", 32'd1, 32'(issue[0]));
	next_step();
	present(0, make_instr(6'd9, 6'd0, 6'd10, issue_pkg::FU_ALU2, 3'd7));
	flush_valid = 1'b1;
	flush_keep  = 8'hbf;
	settle();
	check_value("reader before flush", 32'd0, 32'(issue[0]));
	next_step();
	present(0, make_instr(6'd9, 6'd0, 6'd10, issue_pkg::FU_ALU2, 3'd7));
	settle();
	check_value("reader after flush", 32'd1, 32'(issue[0]));
	check_value("rf data", v, issued[0].data1);
endtask

task automatic operand_selection();
	issue_pkg::renamed_instr_t ins0;
	issue_pkg::renamed_instr_t ins1;
	test_name = "operand_selection";
	reset_dut();
	present(0, make_instr(6'd0, 6'd0, 6'd14, issue_pkg::FU_ALU1, 3'd2));
	settle();
	check_value("writer issue", 32'd1, 32'(issue[0]));
	next_step();
	// both name the pending register but select pc and immediate
	ins0 = make_instr(6'd14, 6'd14, 6'd15, issue_pkg::FU_ALU1, 3'd3);
	ins0.src1_is_pc  = 1'b1;
	ins0.src2_is_imm = 1'b1;
	ins1 = make_instr(6'd14, 6'd14, 6'd16, issue_pkg::FU_ALU2, 3'd4);
	ins1.src1_is_pc  = 1'b1;
	ins1.src2_is_imm = 1'b1;
	present(0, ins0);
	present(1, ins1);
	settle();
	check_value("slot1 issue", 32'd1, 32'(issue[0]));
	check_value("slot2 issue", 32'd1, 32'(issue[1]));
	check_value("slot1 pc", ins0.pc, issued[0].data1);
	check_value("slot1 imm", ins0.immediate, issued[0].data2);
	check_value("slot2 pc", ins1.pc, issued[1].data1);
	check_value("slot2 imm", ins1.immediate, issued[1].data2);
	compare_issued(0, ins0);
	compare_issued(1, ins1);
endtask

/* dv/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 4;
	localparam int NUM_TESTS       = 6;
	// reset plus the longest test, rounded up
	localparam int CYCLES_PER_TEST = 12;
	localparam int WATCHDOG_NS     = 2 * NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

	logic                           clk;
	logic                           rst_n;
	issue_pkg::renamed_instr_t      instr [2];
	logic                           queue_valid [2];
	issue_pkg::commit_t             commit [2];
	issue_pkg::fu_result_t          fu_result [issue_pkg::NUM_FU];
	logic                           busy_lsu;
	logic                           flush_valid;
	logic [issue_pkg::ROB_SIZE-1:0] flush_keep;
	issue_pkg::word_t               data_out_rob [4];
	logic                           issue [2];
	issue_pkg::issued_instr_t       issued [2];
	issue_pkg::ticket_t             read_addr_rob [4];

	int    checks;
	int    errors;
	string test_name;

	issue_stage i_issue_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.queue_valid   (queue_valid),
		.commit        (commit),
		.fu_result     (fu_result),
		.busy_lsu      (busy_lsu),
		.flush_valid   (flush_valid),
		.flush_keep    (flush_keep),
		.data_out_rob  (data_out_rob),
		.issue         (issue),
		.issued        (issued),
		.read_addr_rob (read_addr_rob)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	`include "issue_tests.svh"

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : main
		clk    = 1'b0;
		rst_n  = 1'b0;
		checks = 0;
		errors = 0;
		clear_inputs();
		void'($urandom(32'h6de0));

		commit_and_read();
		stall_and_bypass();
		rob_forward_and_commit();
		pair_rules();
		flush_pending();
		operand_selection();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
	input  logic                          clk,
	input  logic                          rst_n,
	input  issue_pkg::renamed_instr_t     instr [2],
	input  logic                          queue_valid [2],
	input  issue_pkg::commit_t            commit [2],
	input  issue_pkg::fu_result_t         fu_result [issue_pkg::NUM_FU],
	input  logic                          busy_lsu,
	input  logic                          flush_valid,
	input  logic [issue_pkg::ROB_SIZE-1:0] flush_keep,
	input  issue_pkg::word_t              data_out_rob [4],
	output logic                          issue [2],
	output issue_pkg::issued_instr_t      issued [2],
	output issue_pkg::ticket_t            read_addr_rob [4]
);

	logic                  rf_wr_en [2];
	issue_pkg::preg_t      rf_wr_addr [2];
	issue_pkg::word_t      rf_wr_data [2];
	issue_pkg::preg_t      rf_rd_addr [4];
	issue_pkg::word_t      rf_rd_data [4];
	issue_pkg::sb_lookup_t src_lookup [4];
	issue_pkg::sb_lookup_t dst_lookup [2];
	issue_pkg::word_t      op1 [2];
	issue_pkg::word_t      op2 [2];
	logic                  ready [2];

	// only live commits reach the register file
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			rf_wr_en[j]   = commit[j].valid_commit && commit[j].valid_write && !commit[j].flushed;
			rf_wr_addr[j] = commit[j].pdst;
			rf_wr_data[j] = commit[j].data;
		end
	end

	// rob is read at the ticket of each source's producer
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			read_addr_rob[r] = src_lookup[r].ticket;
		end
	end

	register_file i_register_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (rf_wr_en),
		.wr_addr (rf_wr_addr),
		.wr_data (rf_wr_data),
		.rd_addr (rf_rd_addr),
		.rd_data (rf_rd_data)
	);

	scoreboard i_scoreboard (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.issue       (issue),
		.fu_result   (fu_result),
		.commit      (commit),
		.flush_valid (flush_valid),
		.flush_keep  (flush_keep),
		.src_lookup  (src_lookup),
		.dst_lookup  (dst_lookup)
	);

	for (genvar s = 0; s < 2; s++) begin : g_slot
		issue_pkg::sb_lookup_t slot_lookup [2];
		issue_pkg::word_t      slot_rf [2];
		issue_pkg::word_t      slot_rob [2];

		assign rf_rd_addr[2*s]     = instr[s].src1;
		assign rf_rd_addr[2*s + 1] = instr[s].src2;

		assign slot_lookup[0] = src_lookup[2*s];
		assign slot_lookup[1] = src_lookup[2*s + 1];
		assign slot_rf[0]     = rf_rd_data[2*s];
		assign slot_rf[1]     = rf_rd_data[2*s + 1];
		assign slot_rob[0]    = data_out_rob[2*s];
		assign slot_rob[1]    = data_out_rob[2*s + 1];

		operand_bypass i_operand_bypass (
			.instr      (instr[s]),
			.src_lookup (slot_lookup),
			.dst_lookup (dst_lookup[s]),
			.rf_data    (slot_rf),
			.rob_data   (slot_rob),
			.fu_result  (fu_result),
			.busy_lsu   (busy_lsu),
			.data1      (op1[s]),
			.data2      (op2[s]),
			.ready      (ready[s])
		);

		always_comb begin
			issued[s].valid   = issue[s];
			issued[s].pc      = instr[s].pc;
			issued[s].dst     = instr[s].dst;
			issued[s].fu      = instr[s].fu;
			issued[s].microop = instr[s].microop;
			issued[s].ticket  = instr[s].ticket;
			issued[s].data1   = op1[s];
			issued[s].data2   = op2[s];
		end
	end

	issue_select i_issue_select (
		.instr       (instr),
		.queue_valid (queue_valid),
		.ready       (ready),
		.issue       (issue)
	);

endmodule

/* rtl/issue_select.sv */
`timescale 1ns/1ps

module issue_select (
	input  issue_pkg::renamed_instr_t instr [2],
	input  logic                      queue_valid [2],
	input  logic                      ready [2],
	output logic                      issue [2]
);

	logic [1:0] shared_fu;
	logic       reads_src1;
	logic       reads_src2;
	logic       pair_dep;
	logic       both_shared;

	// lsu and csr have one instance each
	assign shared_fu[0] = (instr[0].fu == issue_pkg::FU_LSU) || (instr[0].fu == issue_pkg::FU_CSR);
	assign shared_fu[1] = (instr[1].fu == issue_pkg::FU_LSU) || (instr[1].fu == issue_pkg::FU_CSR);
	assign both_shared  = shared_fu[0] && shared_fu[1];

	// raw between the pair, only for register sources
	assign reads_src1 = !instr[1].src1_is_pc && (instr[1].src1 == instr[0].dst);
	assign reads_src2 = !instr[1].src2_is_imm && (instr[1].src2 == instr[0].dst);
	assign pair_dep   = (reads_src1 || reads_src2) && (instr[0].dst != '0);

	assign issue[0] = queue_valid[0] && instr[0].valid && ready[0];

	// in order, slot 2 only behind slot 1
	assign issue[1] = issue[0] && queue_valid[1] && instr[1].valid && ready[1]
		&& !pair_dep && !both_shared;

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
	input  issue_pkg::renamed_instr_t instr,
	input  issue_pkg::sb_lookup_t     src_lookup [2],
	input  issue_pkg::sb_lookup_t     dst_lookup,
	input  issue_pkg::word_t          rf_data [2],
	input  issue_pkg::word_t          rob_data [2],
	input  issue_pkg::fu_result_t     fu_result [issue_pkg::NUM_FU],
	input  logic                      busy_lsu,
	output issue_pkg::word_t          data1,
	output issue_pkg::word_t          data2,
	output logic                      ready
);

	issue_pkg::preg_t      src_addr [2];
	logic                  src_fixed [2];
	issue_pkg::word_t      fixed_val [2];
	issue_pkg::fu_result_t fwd [2];
	issue_pkg::word_t      src_data [2];
	logic                  src_ok [2];
	logic                  lsu_ok;

	// source 1 may take the pc, source 2 the immediate
	assign src_addr[0]  = instr.src1;
	assign src_addr[1]  = instr.src2;
	assign src_fixed[0] = instr.src1_is_pc;
	assign src_fixed[1] = instr.src2_is_imm;
	assign fixed_val[0] = instr.pc;
	assign fixed_val[1] = instr.immediate;

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			// result bus of the unit that owns the pending value
			fwd[s]      = fu_result[src_lookup[s].fu];
			src_ok[s]   = 1'b1;
			src_data[s] = rf_data[s];
			if (src_fixed[s]) begin
				src_data[s] = fixed_val[s];
			end else if (!src_lookup[s].pending) begin
				src_data[s] = rf_data[s];
			end else if (src_lookup[s].in_rob) begin
				src_data[s] = rob_data[s];
			end else if (fwd[s].valid && (fwd[s].dst == src_addr[s])) begin
				src_data[s] = fwd[s].data;
			end else begin
				// still in flight, wait
				src_ok[s] = 1'b0;
			end
		end
	end

	assign data1 = src_data[0];
	assign data2 = src_data[1];

	// memory ops wait while the lsu is busy
	assign lsu_ok = !((instr.fu == issue_pkg::FU_LSU) && busy_lsu);

	// waw check, p0 is never pending
	assign ready = src_ok[0] && src_ok[1] && !dst_lookup.pending && lsu_ok;

endmodule

/* rtl/scoreboard.sv */
`timescale 1ns/1ps

module scoreboard (
	input  logic                        clk,
	input  logic                        rst_n,
	input  issue_pkg::renamed_instr_t   instr [2],
	input  logic                        issue [2],
	input  issue_pkg::fu_result_t       fu_result [issue_pkg::NUM_FU],
	input  issue_pkg::commit_t          commit [2],
	input  logic                        flush_valid,
	input  logic [issue_pkg::ROB_SIZE-1:0] flush_keep,
	output issue_pkg::sb_lookup_t       src_lookup [4],
	output issue_pkg::sb_lookup_t       dst_lookup [2]
);

	issue_pkg::sb_entry_t sb      [issue_pkg::NUM_PREG];
	issue_pkg::sb_entry_t sb_next [issue_pkg::NUM_PREG];

	// recorded tickets at the result and commit destinations
	issue_pkg::ticket_t res_ticket [issue_pkg::NUM_FU];
	issue_pkg::ticket_t cmt_ticket [2];

	logic [issue_pkg::NUM_FU-1:0] res_hit;
	logic [1:0]                   cmt_hit;

	always_comb begin
		for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
			res_ticket[k] = sb[fu_result[k].dst].ticket;
			// a destination issued this cycle belongs to the new producer
			res_hit[k] = fu_result[k].valid
				&& (fu_result[k].ticket == res_ticket[k])
				&& !(issue[0] && (fu_result[k].dst == instr[0].dst))
				&& !(issue[1] && (fu_result[k].dst == instr[1].dst));
		end
		for (int j = 0; j < 2; j++) begin
			cmt_ticket[j] = sb[commit[j].pdst].ticket;
			cmt_hit[j] = commit[j].valid_commit && commit[j].valid_write
				&& (commit[j].ticket == cmt_ticket[j]);
		end
	end

	// next state, lowest priority written first
	always_comb begin
		for (int i = 0; i < issue_pkg::NUM_PREG; i++) begin
			sb_next[i] = sb[i];

			for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
				if (res_hit[k] && (fu_result[k].dst == issue_pkg::preg_t'(i))) begin
					sb_next[i].in_rob = 1'b1;
				end
			end

			if (cmt_hit[1] && (commit[1].pdst == issue_pkg::preg_t'(i))) begin
				sb_next[i].pending = 1'b0;
			end
			if (cmt_hit[0] && (commit[0].pdst == issue_pkg::preg_t'(i))) begin
				sb_next[i].pending = 1'b0;
			end

			// slot 2 is younger, so it overrides slot 1
			for (int s = 0; s < 2; s++) begin
				if (issue[s] && (instr[s].dst == issue_pkg::preg_t'(i))) begin
					sb_next[i].pending = 1'b1;
					sb_next[i].in_rob  = 1'b0;
					sb_next[i].fu      = instr[s].fu;
					sb_next[i].ticket  = instr[s].ticket;
				end
			end

			if (flush_valid && !flush_keep[sb[i].ticket]) begin
				sb_next[i].pending = 1'b0;
			end
		end
		// p0 is the zero register and never waits
		sb_next[0].pending = 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < issue_pkg::NUM_PREG; i++) begin
				sb[i] <= '0;
			end
		end else begin
			sb <= sb_next;
		end
	end

	// lookups for both slots
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			src_lookup[2*s]     = sb[instr[s].src1];
			src_lookup[2*s + 1] = sb[instr[s].src2];
			dst_lookup[s]       = sb[instr[s].dst];
		end
	end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en [2],
	input  issue_pkg::preg_t  wr_addr [2],
	input  issue_pkg::word_t  wr_data [2],
	input  issue_pkg::preg_t  rd_addr [4],
	output issue_pkg::word_t  rd_data [4]
);

	issue_pkg::word_t regs [issue_pkg::NUM_PREG];

	// two commit ports, the later port wins on a collision
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < issue_pkg::NUM_PREG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				// p0 stays zero
				if (wr_en[p] && (wr_addr[p] != '0)) begin
					regs[wr_addr[p]] <= wr_data[p];
				end
			end
		end
	end

	// reads see the value before this cycle's writes
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			rd_data[r] = regs[rd_addr[r]];
		end
	end

endmodule

/* rtl/issue_pkg.sv */
package issue_pkg;

	// base widths
	localparam int PREG_W   = 6;
	localparam int TICKET_W = 3;
	localparam int WORD_W   = 32;
	localparam int UOP_W    = 5;

	typedef logic [PREG_W-1:0]   preg_t;
	typedef logic [TICKET_W-1:0] ticket_t;
	typedef logic [WORD_W-1:0]   word_t;

	// counts follow from the widths above
	localparam int NUM_PREG = 1 << PREG_W;
	localparam int ROB_SIZE = 1 << TICKET_W;
	localparam int NUM_FU   = 4;

	// lsu and csr are the shared units
	typedef enum logic [1:0] {
		FU_LSU  = 2'd0,
		FU_CSR  = 2'd1,
		FU_ALU1 = 2'd2,
		FU_ALU2 = 2'd3
	} fu_kind_e;

	// entry from the issue queue, already renamed
	typedef struct packed {
		logic             valid;
		word_t            pc;
		preg_t            src1;
		preg_t            src2;
		preg_t            dst;
		word_t            immediate;
		logic             src1_is_pc;
		logic             src2_is_imm;
		fu_kind_e         fu;
		logic [UOP_W-1:0] microop;
		ticket_t          ticket;
	} renamed_instr_t;

	// toward the execution units
	typedef struct packed {
		logic             valid;
		word_t            pc;
		preg_t            dst;
		fu_kind_e         fu;
		logic [UOP_W-1:0] microop;
		ticket_t          ticket;
		word_t            data1;
		word_t            data2;
	} issued_instr_t;

	typedef struct packed {
		logic    valid;
		preg_t   dst;
		ticket_t ticket;
		word_t   data;
	} fu_result_t;

	// retirement from the rob
	typedef struct packed {
		logic    valid_commit;
		logic    valid_write;
		logic    flushed;
		preg_t   pdst;
		ticket_t ticket;
		word_t   data;
	} commit_t;

	typedef struct packed {
		logic     pending;
		logic     in_rob;
		fu_kind_e fu;
		ticket_t  ticket;
	} sb_entry_t;

	// a lookup returns the entry of the named register
	typedef sb_entry_t sb_lookup_t;

endpackage
